//--- hdl/mips_pkg.sv
package mips_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int IMM_W      = 16;
  localparam int OPFIELD_W  = 6;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [IMM_W-1:0]      imm_t;
  typedef logic [OPFIELD_W-1:0]  opfield_t;

  // return address register for jal
  localparam reg_addr_t REG_LINK = 5'd31;

  typedef enum logic [1:0] {
    EXT_SIGN  = 2'd0,
    EXT_ZERO  = 2'd1,
    EXT_UPPER = 2'd2  // imm in [31:16] with zeros below
  } ext_mode_e;

  // word is zero so an idle or flushed ctrl is a plain word access
  typedef enum logic [2:0] {
    WS_WORD   = 3'd0,
    WS_BYTE   = 3'd1,
    WS_HALF   = 3'd2,
    WS_BYTE_U = 3'd3,
    WS_HALF_U = 3'd4
  } word_size_e;

  localparam opfield_t OP_RTYPE = 6'b000000;
  localparam opfield_t OP_J     = 6'b000010;
  localparam opfield_t OP_JAL   = 6'b000011;
  localparam opfield_t OP_BEQ   = 6'b000100;
  localparam opfield_t OP_BNE   = 6'b000101;
  localparam opfield_t OP_ADDI  = 6'b001000;
  localparam opfield_t OP_ADDIU = 6'b001001;
  localparam opfield_t OP_ANDI  = 6'b001100;
  localparam opfield_t OP_ORI   = 6'b001101;
  localparam opfield_t OP_LUI   = 6'b001111;
  localparam opfield_t OP_LB    = 6'b100000;
  localparam opfield_t OP_LH    = 6'b100001;
  localparam opfield_t OP_LW    = 6'b100011;
  localparam opfield_t OP_LBU   = 6'b100100;
  localparam opfield_t OP_LHU   = 6'b100101;
  localparam opfield_t OP_SB    = 6'b101000;
  localparam opfield_t OP_SH    = 6'b101001;
  localparam opfield_t OP_SW    = 6'b101011;

  typedef struct packed {
    logic       alu_src;    // operand b from immediate
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       branch;
    logic       jump;
    word_size_e word_size;
  } ctrl_t;

  // bundle handed to execute
  typedef struct packed {
    ctrl_t     ctrl;
    word_t     data_a;   // rs value
    word_t     data_b;   // rt value
    word_t     ext_imm;
    opfield_t  op_code;
    opfield_t  funct;
    reg_addr_t reg_dst;
  } id_ex_t;

endpackage

//--- hdl/control_unit.sv
module control_unit (
  input  mips_pkg::opfield_t  i_op_code,
  output mips_pkg::ctrl_t     o_ctrl,
  output mips_pkg::ext_mode_e o_ext_mode,
  output logic                o_dst_sel_rd,  // write to rd instead of rt
  output logic                o_dst_link     // write to r31
);

  always_comb begin
    o_ctrl           = '0;
    o_ctrl.word_size = mips_pkg::WS_WORD;
    o_ext_mode       = mips_pkg::EXT_SIGN;
    o_dst_sel_rd     = 1'b0;
    o_dst_link       = 1'b0;

    case (i_op_code)
      mips_pkg::OP_RTYPE: begin
        o_ctrl.reg_write = 1'b1;  // alu op comes from funct
        o_dst_sel_rd     = 1'b1;
      end

      mips_pkg::OP_ADDI,
      mips_pkg::OP_ADDIU: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
      end

      mips_pkg::OP_ANDI,
      mips_pkg::OP_ORI: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
        o_ext_mode       = mips_pkg::EXT_ZERO;  // logical ops
      end

      mips_pkg::OP_LUI: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
        o_ext_mode       = mips_pkg::EXT_UPPER;
      end

      mips_pkg::OP_LW,
      mips_pkg::OP_LH,
      mips_pkg::OP_LHU,
      mips_pkg::OP_LB,
      mips_pkg::OP_LBU: begin
        o_ctrl.mem_read  = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;  // base + offset
        case (i_op_code)
          mips_pkg::OP_LH:  o_ctrl.word_size = mips_pkg::WS_HALF;
          mips_pkg::OP_LHU: o_ctrl.word_size = mips_pkg::WS_HALF_U;
          mips_pkg::OP_LB:  o_ctrl.word_size = mips_pkg::WS_BYTE;
          mips_pkg::OP_LBU: o_ctrl.word_size = mips_pkg::WS_BYTE_U;
          default:          o_ctrl.word_size = mips_pkg::WS_WORD;
        endcase
      end

      mips_pkg::OP_SW,
      mips_pkg::OP_SH,
      mips_pkg::OP_SB: begin
        o_ctrl.mem_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
        case (i_op_code)
          mips_pkg::OP_SH: o_ctrl.word_size = mips_pkg::WS_HALF;
          mips_pkg::OP_SB: o_ctrl.word_size = mips_pkg::WS_BYTE;
          default:         o_ctrl.word_size = mips_pkg::WS_WORD;
        endcase
      end

      mips_pkg::OP_BEQ,
      mips_pkg::OP_BNE: begin
        o_ctrl.branch = 1'b1;  // compare happens in ex
      end

      mips_pkg::OP_J: begin
        o_ctrl.jump = 1'b1;
      end

      mips_pkg::OP_JAL: begin
        o_ctrl.jump      = 1'b1;
        o_ctrl.reg_write = 1'b1;  // link address
        o_dst_link       = 1'b1;
      end

      default: begin
        o_ctrl = '0;  // unknown opcode
      end
    endcase
  end

endmodule

//--- hdl/register_file.sv
module register_file #(
  parameter int REGS = 32
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_step,
  input  logic                i_wb_we,
  input  mips_pkg::reg_addr_t i_wb_addr,
  input  mips_pkg::word_t     i_wb_data,
  input  mips_pkg::reg_addr_t i_rs_addr,
  input  mips_pkg::reg_addr_t i_rt_addr,
  output mips_pkg::word_t     o_rs_data,
  output mips_pkg::word_t     o_rt_data,
  input  mips_pkg::reg_addr_t i_dbg_addr,
  output mips_pkg::word_t     o_dbg_data
);

  mips_pkg::word_t regs [REGS];
  logic            wr_en;

  // r0 is hardwired and never written
  assign wr_en = i_step && i_wb_we && (i_wb_addr != '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_wb_addr] <= i_wb_data;
    end
  end

  // same read path for all three ports
  function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
    mips_pkg::word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (wr_en && (addr == i_wb_addr)) begin
      data = i_wb_data;  // write-through bypass
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  assign o_rs_data  = read_port(i_rs_addr);
  assign o_rt_data  = read_port(i_rt_addr);
  assign o_dbg_data = read_port(i_dbg_addr);

endmodule

//--- hdl/imm_extender.sv
module imm_extender (
  input  mips_pkg::imm_t      i_imm,
  input  mips_pkg::ext_mode_e i_mode,
  output mips_pkg::word_t     o_ext
);

  localparam int PAD_W = mips_pkg::WORD_W - mips_pkg::IMM_W;

  logic sign_bit;

  assign sign_bit = i_imm[mips_pkg::IMM_W-1];

  always_comb begin
    case (i_mode)
      mips_pkg::EXT_ZERO: begin
        o_ext = {{PAD_W{1'b0}}, i_imm};
      end
      mips_pkg::EXT_UPPER: begin
        o_ext = {i_imm, {PAD_W{1'b0}}};  // lui
      end
      default: begin
        o_ext = {{PAD_W{sign_bit}}, i_imm};  // sign extend
      end
    endcase
  end

endmodule

//--- hdl/id_ex_latch.sv
module id_ex_latch (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_step,
  input  logic             i_flush,
  input  mips_pkg::id_ex_t i_bundle,
  output mips_pkg::id_ex_t o_bundle
);

  mips_pkg::id_ex_t bundle_q;
  mips_pkg::id_ex_t bundle_d;

  // a flush keeps the data but kills every control bit
  always_comb begin
    bundle_d = i_bundle;
    if (i_flush) begin
      bundle_d.ctrl = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      bundle_q <= '0;  // bubble
    end else if (i_step) begin
      bundle_q <= bundle_d;
    end
  end

  assign o_bundle = bundle_q;

endmodule

//--- hdl/decode_stage.sv
module decode_stage #(
  parameter int REGS = 32
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_step,
  input  logic                i_flush,
  input  mips_pkg::word_t     i_instruction,
  input  logic                i_wb_we,
  input  mips_pkg::reg_addr_t i_wb_addr,
  input  mips_pkg::word_t     i_wb_data,
  input  mips_pkg::reg_addr_t i_dbg_reg_num,
  output mips_pkg::word_t     o_dbg_reg_data,
  output mips_pkg::id_ex_t    o_id_ex
);

  mips_pkg::opfield_t  op_code;
  mips_pkg::opfield_t  funct;
  mips_pkg::reg_addr_t rs;
  mips_pkg::reg_addr_t rt;
  mips_pkg::reg_addr_t rd;
  mips_pkg::imm_t      imm;

  mips_pkg::ctrl_t     ctrl;
  mips_pkg::ext_mode_e ext_mode;
  logic                dst_sel_rd;
  logic                dst_link;
  mips_pkg::reg_addr_t reg_dst;

  mips_pkg::word_t     rs_data;
  mips_pkg::word_t     rt_data;
  mips_pkg::word_t     ext_imm;
  mips_pkg::id_ex_t    id_bundle;

  // instruction fields
  assign op_code = i_instruction[31:26];
  assign rs      = i_instruction[25:21];
  assign rt      = i_instruction[20:16];
  assign rd      = i_instruction[15:11];
  assign imm     = i_instruction[15:0];
  assign funct   = i_instruction[5:0];

  control_unit u_control_unit (
    .i_op_code    (op_code),
    .o_ctrl       (ctrl),
    .o_ext_mode   (ext_mode),
    .o_dst_sel_rd (dst_sel_rd),
    .o_dst_link   (dst_link)
  );

  register_file #(
    .REGS (REGS)
  ) u_register_file (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_step     (i_step),
    .i_wb_we    (i_wb_we),
    .i_wb_addr  (i_wb_addr),
    .i_wb_data  (i_wb_data),
    .i_rs_addr  (rs),
    .i_rt_addr  (rt),
    .o_rs_data  (rs_data),
    .o_rt_data  (rt_data),
    .i_dbg_addr (i_dbg_reg_num),
    .o_dbg_data (o_dbg_reg_data)
  );

  imm_extender u_imm_extender (
    .i_imm  (imm),
    .i_mode (ext_mode),
    .o_ext  (ext_imm)
  );

  // link wins over the rd/rt choice
  assign reg_dst = dst_link   ? mips_pkg::REG_LINK :
                   dst_sel_rd ? rd : rt;

  always_comb begin
    id_bundle.ctrl    = ctrl;
    id_bundle.data_a  = rs_data;
    id_bundle.data_b  = rt_data;
    id_bundle.ext_imm = ext_imm;
    id_bundle.op_code = op_code;
    id_bundle.funct   = funct;
    id_bundle.reg_dst = reg_dst;
  end

  id_ex_latch u_id_ex_latch (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_step   (i_step),
    .i_flush  (i_flush),
    .i_bundle (id_bundle),
    .o_bundle (o_id_ex)
  );

endmodule

//--- include/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// register contents as the write-back port should have left them
mips_pkg::word_t shadow [32];

function automatic mips_pkg::ctrl_t ctrl_for_op(input mips_pkg::opfield_t op);
  mips_pkg::ctrl_t c;
  c = '0;
  if (op == mips_pkg::OP_RTYPE) begin
    c.reg_write = 1'b1;
  end else if (op inside {mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI,
                          mips_pkg::OP_ORI, mips_pkg::OP_LUI}) begin
    c.reg_write = 1'b1;
    c.alu_src   = 1'b1;
  end else if (op inside {mips_pkg::OP_LW, mips_pkg::OP_LH, mips_pkg::OP_LHU,
                          mips_pkg::OP_LB, mips_pkg::OP_LBU}) begin
    c.mem_read  = 1'b1;
    c.reg_write = 1'b1;
    c.alu_src   = 1'b1;
  end else if (op inside {mips_pkg::OP_SW, mips_pkg::OP_SH, mips_pkg::OP_SB}) begin
    c.mem_write = 1'b1;
    c.alu_src   = 1'b1;
  end else if (op inside {mips_pkg::OP_BEQ, mips_pkg::OP_BNE}) begin
    c.branch = 1'b1;
  end else if (op == mips_pkg::OP_J) begin
    c.jump = 1'b1;
  end else if (op == mips_pkg::OP_JAL) begin
    c.jump      = 1'b1;
    c.reg_write = 1'b1;
  end
  case (op)
    mips_pkg::OP_LB, mips_pkg::OP_SB: c.word_size = mips_pkg::WS_BYTE;
    mips_pkg::OP_LH, mips_pkg::OP_SH: c.word_size = mips_pkg::WS_HALF;
    mips_pkg::OP_LBU:                 c.word_size = mips_pkg::WS_BYTE_U;
    mips_pkg::OP_LHU:                 c.word_size = mips_pkg::WS_HALF_U;
    default:                          c.word_size = mips_pkg::WS_WORD;
  endcase
  return c;
endfunction

function automatic mips_pkg::word_t extend_imm(input mips_pkg::opfield_t op,
                                               input mips_pkg::imm_t imm);
  mips_pkg::word_t ext;
  if (op == mips_pkg::OP_ANDI || op == mips_pkg::OP_ORI) begin
    ext = {16'h0000, imm};
  end else if (op == mips_pkg::OP_LUI) begin
    ext = {imm, 16'h0000};
  end else begin
    ext = {{16{imm[15]}}, imm};
  end
  return ext;
endfunction

function automatic mips_pkg::reg_addr_t dest_reg(input mips_pkg::word_t instr);
  mips_pkg::reg_addr_t dst;
  if (instr[31:26] == mips_pkg::OP_RTYPE) begin
    dst = instr[15:11];
  end else if (instr[31:26] == mips_pkg::OP_JAL) begin
    dst = 5'd31;
  end else begin
    dst = instr[20:16];
  end
  return dst;
endfunction

// what a read port shows, including a write in the same cycle
function automatic mips_pkg::word_t register_value(input mips_pkg::reg_addr_t addr,
                                                   input logic wr,
                                                   input mips_pkg::reg_addr_t waddr,
                                                   input mips_pkg::word_t wdata,
                                                   input mips_pkg::word_t stored);
  mips_pkg::word_t value;
  if (addr == '0) begin
    value = '0;
  end else if (wr && addr == waddr) begin
    value = wdata;
  end else begin
    value = stored;
  end
  return value;
endfunction

function automatic mips_pkg::id_ex_t predict_bundle(input mips_pkg::word_t instr,
                                                    input logic flush,
                                                    input logic we,
                                                    input mips_pkg::reg_addr_t waddr,
                                                    input mips_pkg::word_t wdata);
  mips_pkg::id_ex_t    b;
  mips_pkg::reg_addr_t rs;
  mips_pkg::reg_addr_t rt;
  rs = instr[25:21];
  rt = instr[20:16];
  if (flush) begin
    b.ctrl = '0;  // bubble
  end else begin
    b.ctrl = ctrl_for_op(instr[31:26]);
  end
  b.data_a  = register_value(rs, we, waddr, wdata, shadow[rs]);
  b.data_b  = register_value(rt, we, waddr, wdata, shadow[rt]);
  b.ext_imm = extend_imm(instr[31:26], instr[15:0]);
  b.op_code = instr[31:26];
  b.funct   = instr[5:0];
  b.reg_dst = dest_reg(instr);
  return b;
endfunction

task automatic update_shadow(input mips_pkg::reg_addr_t addr, input mips_pkg::word_t data);
  if (addr != '0) begin
    shadow[addr] = data;
  end
endtask

`endif

//--- sim/tb_decode_stage.sv
module tb_decode_stage;

  localparam int REGS           = 32;
  localparam int SEED           = 69835;
  localparam int RESET_CYCLES   = 8;
  localparam int N_OPS          = 19;
  localparam int REPS           = 4;
  localparam int HOLD_CYCLES    = 10;
  localparam int FLUSH_CYCLES   = 10;
  localparam int TEST_CYCLES    = RESET_CYCLES + 3 * REGS + N_OPS * REPS
                                  + HOLD_CYCLES + FLUSH_CYCLES + 4;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 50;

  // every supported opcode, then one the decoder does not know
  localparam mips_pkg::opfield_t OP_LIST [N_OPS] = '{
    mips_pkg::OP_RTYPE, mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI,
    mips_pkg::OP_ORI, mips_pkg::OP_LUI, mips_pkg::OP_LW, mips_pkg::OP_LH,
    mips_pkg::OP_LHU, mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_SW,
    mips_pkg::OP_SH, mips_pkg::OP_SB, mips_pkg::OP_BEQ, mips_pkg::OP_BNE,
    mips_pkg::OP_J, mips_pkg::OP_JAL, 6'b111111
  };

  logic                i_clk;
  logic                i_rst_n;
  logic                i_step;
  logic                i_flush;
  mips_pkg::word_t     i_instruction;
  logic                i_wb_we;
  mips_pkg::reg_addr_t i_wb_addr;
  mips_pkg::word_t     i_wb_data;
  mips_pkg::reg_addr_t i_dbg_reg_num;
  mips_pkg::word_t     o_dbg_reg_data;
  mips_pkg::id_ex_t    o_id_ex;

  mips_pkg::id_ex_t    exp_bundle;
  mips_pkg::word_t     exp_dbg;
  logic                chk_on;
  int                  cycle_count = 0;

  `include "decode_model.svh"

  decode_stage #(
    .REGS (REGS)
  ) uut (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_step         (i_step),
    .i_flush        (i_flush),
    .i_instruction  (i_instruction),
    .i_wb_we        (i_wb_we),
    .i_wb_addr      (i_wb_addr),
    .i_wb_data      (i_wb_data),
    .i_dbg_reg_num  (i_dbg_reg_num),
    .o_dbg_reg_data (o_dbg_reg_data),
    .o_id_ex        (o_id_ex)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // expectation lags the stepped instruction by one edge like the latch
  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      exp_bundle <= '0;
      for (int i = 0; i < 32; i++) begin
        shadow[i] = '0;
      end
    end else if (i_step) begin
      exp_bundle <= predict_bundle(i_instruction, i_flush, i_wb_we, i_wb_addr, i_wb_data);
      if (i_wb_we) begin
        update_shadow(i_wb_addr, i_wb_data);
      end
    end
  end

  assign exp_dbg = register_value(i_dbg_reg_num, i_step && i_wb_we, i_wb_addr, i_wb_data,
                                  shadow[i_dbg_reg_num]);

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic flag_mismatch(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("MISMATCH %s: expected 0x%08h, got 0x%08h", field, exp, act);
    $display("Test failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  ctrl_check: assert property (@(posedge i_clk) disable iff (!chk_on)
      o_id_ex.ctrl == exp_bundle.ctrl)
    else flag_mismatch("ctrl", {23'h0, $sampled(exp_bundle.ctrl)},
                       {23'h0, $sampled(o_id_ex.ctrl)});
  data_a_check: assert property (@(posedge i_clk) disable iff (!chk_on)
      o_id_ex.data_a == exp_bundle.data_a)
    else flag_mismatch("data_a", $sampled(exp_bundle.data_a), $sampled(o_id_ex.data_a));
  data_b_check: assert property (@(posedge i_clk) disable iff (!chk_on)
      o_id_ex.data_b == exp_bundle.data_b)
    else flag_mismatch("data_b", $sampled(exp_bundle.data_b), $sampled(o_id_ex.data_b));
  ext_imm_check: assert property (@(posedge i_clk) disable iff (!chk_on)
      o_id_ex.ext_imm == exp_bundle.ext_imm)
    else flag_mismatch("ext_imm", $sampled(exp_bundle.ext_imm), $sampled(o_id_ex.ext_imm));
  op_code_check: assert property (@(posedge i_clk) disable iff (!chk_on)
      o_id_ex.op_code == exp_bundle.op_code)
    else flag_mismatch("op_code", {26'h0, $sampled(exp_bundle.op_code)},
                       {26'h0, $sampled(o_id_ex.op_code)});
  funct_check: assert property (@(posedge i_clk) disable iff (!chk_on)
      o_id_ex.funct == exp_bundle.funct)
    else flag_mismatch("funct", {26'h0, $sampled(exp_bundle.funct)},
                       {26'h0, $sampled(o_id_ex.funct)});
  reg_dst_check: assert property (@(posedge i_clk) disable iff (!chk_on)
      o_id_ex.reg_dst == exp_bundle.reg_dst)
    else flag_mismatch("reg_dst", {27'h0, $sampled(exp_bundle.reg_dst)},
                       {27'h0, $sampled(o_id_ex.reg_dst)});
  dbg_check: assert property (@(posedge i_clk) disable iff (!chk_on)
      o_dbg_reg_data == exp_dbg)
    else flag_mismatch("o_dbg_reg_data", $sampled(exp_dbg), $sampled(o_dbg_reg_data));

  function automatic mips_pkg::word_t random_instr(input mips_pkg::opfield_t op);
    mips_pkg::word_t body;
    body = $urandom();
    return {op, body[25:0]};
  endfunction

  task automatic drive_cycle(input mips_pkg::word_t instr, input logic step,
                             input logic flush, input logic we,
                             input mips_pkg::reg_addr_t waddr, input mips_pkg::word_t wdata,
                             input mips_pkg::reg_addr_t dbg);
    @(posedge i_clk);
    i_instruction <= instr;
    i_step        <= step;
    i_flush       <= flush;
    i_wb_we       <= we;
    i_wb_addr     <= waddr;
    i_wb_data     <= wdata;
    i_dbg_reg_num <= dbg;
  endtask

  initial begin
    mips_pkg::word_t     instr;
    mips_pkg::reg_addr_t addr;
    void'($urandom(SEED));
    i_rst_n       = 1'b0;
    i_step        = 1'b0;
    i_flush       = 1'b0;
    i_instruction = '0;
    i_wb_we       = 1'b0;
    i_wb_addr     = '0;
    i_wb_data     = '0;
    i_dbg_reg_num = '0;
    chk_on        = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst_n <= 1'b1;
    chk_on  <= 1'b1;

    for (int r = 0; r < REGS; r++) begin  // all zero after reset
      drive_cycle('0, 1'b0, 1'b0, 1'b0, '0, '0, 5'(r));
    end
    for (int r = 0; r < REGS; r++) begin  // write and read back through bypass
      drive_cycle(random_instr(OP_LIST[r % N_OPS]), 1'b1, 1'b0, 1'b1, 5'(r), $urandom(),
                  5'(r));
    end
    for (int r = 0; r < REGS; r++) begin
      drive_cycle('0, 1'b0, 1'b0, 1'b0, '0, '0, 5'(r));
    end

    for (int i = 0; i < N_OPS * REPS; i++) begin
      instr = random_instr(OP_LIST[i % N_OPS]);
      addr  = ($urandom_range(1, 0) != 0) ? instr[25:21] : 5'($urandom);  // often rs
      drive_cycle(instr, 1'b1, 1'b0, 1'($urandom), addr, $urandom(), 5'($urandom));
    end

    // latch holds and repeated writes to one register never land while stalled
    addr = 5'($urandom_range(31, 1));
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      drive_cycle(random_instr(OP_LIST[i]), 1'b0, 1'b0, 1'b1, addr, $urandom(), addr);
    end
    for (int i = 0; i < FLUSH_CYCLES; i++) begin
      instr = random_instr(OP_LIST[$urandom_range(N_OPS - 1, 0)]);
      drive_cycle(instr, 1'b1, 1'b1, 1'($urandom), 5'($urandom), $urandom(),
                  5'($urandom));
    end

    repeat (3) begin
      drive_cycle('0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    end
    @(posedge i_clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
hdl/mips_pkg.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/imm_extender.sv
hdl/id_ex_latch.sv
hdl/decode_stage.sv
sim/tb_decode_stage.sv

//--- Makefile
TOP := tb_decode_stage

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module decode_stage
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
